// ==== logic/exu_params.svh ====
`ifndef EXU_PARAMS_SVH
`define EXU_PARAMS_SVH

// data path and pc width
`define EXU_XLEN 64

// register index width
`define EXU_REG_ADDR_W 5

// architectural registers, x0 included
`define EXU_NUM_REGS 32

// sequential pc step, no compressed instructions
`define EXU_INSN_STEP 4

`endif

// ==== logic/exu_pkg.sv ====
package exu_pkg;

    // decoded opcode, one per supported instruction
    typedef enum logic [4:0] {
        op_add,
        op_sub,
        op_sll,
        op_slt,
        op_sltu,
        op_xor,
        op_srl,
        op_sra,
        op_or,
        op_and,
        // word forms, 32-bit result sign extended
        op_addw,
        op_subw,
        op_sllw,
        op_srlw,
        op_sraw,
        // upper immediate and jumps
        op_lui,
        op_auipc,
        op_jal,
        op_jalr,
        // conditional branches
        op_beq,
        op_bne,
        op_blt,
        op_bge,
        op_bltu,
        op_bgeu
    } exu_op_e;

    // alu function select
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_mode_e;

endpackage

// ==== logic/exu_stage_if.sv ====
`timescale 1ns/100ps

`include "exu_params.svh"

// one instruction from operand stage to execute stage
interface exu_stage_if import exu_pkg::*; ();

    // single cycle strobe, no ready
    logic                       valid;
    exu_op_e                    op;
    logic [`EXU_REG_ADDR_W-1:0] rd;
    logic [`EXU_XLEN-1:0]       pc;
    logic [`EXU_XLEN-1:0]       imm;
    // alu inputs, already muxed
    logic [`EXU_XLEN-1:0]       operand_a;
    logic [`EXU_XLEN-1:0]       operand_b;
    // raw register values for branch compare
    logic [`EXU_XLEN-1:0]       src1;
    logic [`EXU_XLEN-1:0]       src2;

    modport producer (
        output valid, op, rd, pc, imm, operand_a, operand_b, src1, src2
    );

    modport consumer (
        input valid, op, rd, pc, imm, operand_a, operand_b, src1, src2
    );

endinterface

// ==== logic/exu_reg_file.sv ====
`timescale 1ns/100ps

`include "exu_params.svh"

module exu_reg_file (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [`EXU_REG_ADDR_W-1:0] rs1_addr,
    input  logic [`EXU_REG_ADDR_W-1:0] rs2_addr,
    input  logic                       wen,
    input  logic [`EXU_REG_ADDR_W-1:0] waddr,
    input  logic [`EXU_XLEN-1:0]       wdata,
    output logic [`EXU_XLEN-1:0]       rs1_data,
    output logic [`EXU_XLEN-1:0]       rs2_data
);

    logic [`EXU_XLEN-1:0] regs [`EXU_NUM_REGS];

    // x0 is cleared by reset and never written, so it stays zero
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `EXU_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // async read ports, bypass lives in the operand stage
    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

endmodule

// ==== logic/exu_operand_stage.sv ====
`timescale 1ns/100ps

`include "exu_params.svh"

module exu_operand_stage import exu_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n,
    // decoded instruction strobe
    input  logic                       in_valid,
    input  exu_op_e                    in_op,
    input  logic                       in_use_imm,
    input  logic [`EXU_REG_ADDR_W-1:0] in_rd,
    input  logic [`EXU_REG_ADDR_W-1:0] in_rs1,
    input  logic [`EXU_REG_ADDR_W-1:0] in_rs2,
    input  logic [`EXU_XLEN-1:0]       in_imm,
    input  logic [`EXU_XLEN-1:0]       in_pc,
    // register file read
    output logic [`EXU_REG_ADDR_W-1:0] rf_rs1_addr,
    output logic [`EXU_REG_ADDR_W-1:0] rf_rs2_addr,
    input  logic [`EXU_XLEN-1:0]       rf_rs1_data,
    input  logic [`EXU_XLEN-1:0]       rf_rs2_data,
    // bypass from the instruction one slot ahead
    input  logic                       ex_fwd_valid,
    input  logic [`EXU_REG_ADDR_W-1:0] ex_fwd_rd,
    input  logic [`EXU_XLEN-1:0]       ex_fwd_data,
    // bypass from the instruction two slots ahead
    input  logic                       wb_wen,
    input  logic [`EXU_REG_ADDR_W-1:0] wb_rd,
    input  logic [`EXU_XLEN-1:0]       wb_data,
    exu_stage_if.producer              stage
);

    logic [`EXU_XLEN-1:0] src1;
    logic [`EXU_XLEN-1:0] src2;
    logic [`EXU_XLEN-1:0] operand_a;
    logic [`EXU_XLEN-1:0] operand_b;

    // youngest producer wins, x0 always zero
    function automatic logic [`EXU_XLEN-1:0] resolve_src(
        input logic [`EXU_REG_ADDR_W-1:0] idx,
        input logic [`EXU_XLEN-1:0]       rf_data
    );
        logic [`EXU_XLEN-1:0] value;
        if (idx == '0) begin
            value = '0;
        end else if (ex_fwd_valid && ex_fwd_rd == idx) begin
            value = ex_fwd_data;
        end else if (wb_wen && wb_rd == idx) begin
            value = wb_data;
        end else begin
            value = rf_data;
        end
        return value;
    endfunction

    assign rf_rs1_addr = in_rs1;
    assign rf_rs2_addr = in_rs2;

    always_comb begin
        src1 = resolve_src(in_rs1, rf_rs1_data);
        src2 = resolve_src(in_rs2, rf_rs2_data);
    end

    // pc relative ops add to pc, the rest to rs1
    assign operand_a = (in_op inside {op_auipc, op_jal}) ? in_pc : src1;
    // jumps and upper immediates always take imm
    assign operand_b = (in_use_imm || in_op inside {op_jal, op_jalr, op_lui, op_auipc})
                       ? in_imm : src2;

    // control
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stage.valid <= 1'b0;
            stage.op    <= op_add;
            stage.rd    <= '0;
        end else begin
            stage.valid <= in_valid;
            stage.op    <= in_op;
            stage.rd    <= in_rd;
        end
    end

    // payload, only loaded with a new instruction
    always_ff @(posedge clk) begin
        if (in_valid) begin
            stage.pc        <= in_pc;
            stage.imm       <= in_imm;
            stage.operand_a <= operand_a;
            stage.operand_b <= operand_b;
            stage.src1      <= src1;
            stage.src2      <= src2;
        end
    end

endmodule

// ==== logic/exu_execute_stage.sv ====
`timescale 1ns/100ps

`include "exu_params.svh"

module exu_execute_stage import exu_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n,
    exu_stage_if.consumer              stage,
    // combinational result, bypassed to the operand stage
    output logic                       ex_fwd_valid,
    output logic [`EXU_REG_ADDR_W-1:0] ex_fwd_rd,
    output logic [`EXU_XLEN-1:0]       ex_fwd_data,
    // registered writeback
    output logic                       wb_wen,
    output logic [`EXU_REG_ADDR_W-1:0] wb_rd,
    output logic [`EXU_XLEN-1:0]       wb_data,
    output logic                       out_valid,
    output logic [`EXU_XLEN-1:0]       out_next_pc
);

    alu_mode_e            mode;
    logic                 is_word;
    logic                 is_branch;
    logic                 taken;
    logic [31:0]          word_res;
    logic [`EXU_XLEN-1:0] alu_res;
    logic [`EXU_XLEN-1:0] alu_ext;
    logic [`EXU_XLEN-1:0] seq_pc;
    logic [`EXU_XLEN-1:0] rel_pc;
    logic [`EXU_XLEN-1:0] result;
    logic [`EXU_XLEN-1:0] next_pc;

    assign is_word   = stage.op inside {op_addw, op_subw, op_sllw, op_srlw, op_sraw};
    assign is_branch = stage.op inside {op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu};

    // opcode to alu function
    always_comb begin
        case (stage.op)
            op_sub, op_subw:  mode = alu_sub;
            op_sll, op_sllw:  mode = alu_sll;
            op_slt:           mode = alu_slt;
            op_sltu:          mode = alu_sltu;
            op_xor:           mode = alu_xor;
            op_srl, op_srlw:  mode = alu_srl;
            op_sra, op_sraw:  mode = alu_sra;
            op_or:            mode = alu_or;
            op_and:           mode = alu_and;
            // add, auipc, jal, jalr address sums
            default:          mode = alu_add;
        endcase
    end

    // word shifts work on the low half with a 5-bit amount
    always_comb begin
        case (mode)
            alu_sll: word_res = stage.operand_a[31:0] << stage.operand_b[4:0];
            alu_srl: word_res = stage.operand_a[31:0] >> stage.operand_b[4:0];
            alu_sra: word_res = $signed(stage.operand_a[31:0]) >>> stage.operand_b[4:0];
            default: word_res = alu_res[31:0];
        endcase
    end

    always_comb begin
        case (mode)
            alu_sub:  alu_res = stage.operand_a - stage.operand_b;
            alu_sll:  alu_res = stage.operand_a << stage.operand_b[5:0];
            alu_slt:  alu_res = {63'b0, $signed(stage.operand_a) < $signed(stage.operand_b)};
            alu_sltu: alu_res = {63'b0, stage.operand_a < stage.operand_b};
            alu_xor:  alu_res = stage.operand_a ^ stage.operand_b;
            alu_srl:  alu_res = stage.operand_a >> stage.operand_b[5:0];
            alu_sra:  alu_res = $signed(stage.operand_a) >>> stage.operand_b[5:0];
            alu_or:   alu_res = stage.operand_a | stage.operand_b;
            alu_and:  alu_res = stage.operand_a & stage.operand_b;
            default:  alu_res = stage.operand_a + stage.operand_b;
        endcase
    end

    // sign extend the 32-bit word result
    assign alu_ext = is_word ? {{32{word_res[31]}}, word_res} : alu_res;

    // branch condition on raw register values
    always_comb begin
        case (stage.op)
            op_beq:  taken = stage.src1 == stage.src2;
            op_bne:  taken = stage.src1 != stage.src2;
            op_blt:  taken = $signed(stage.src1) < $signed(stage.src2);
            op_bge:  taken = $signed(stage.src1) >= $signed(stage.src2);
            op_bltu: taken = stage.src1 < stage.src2;
            op_bgeu: taken = stage.src1 >= stage.src2;
            default: taken = 1'b0;
        endcase
    end

    assign seq_pc = stage.pc + `EXU_XLEN'(`EXU_INSN_STEP);
    assign rel_pc = stage.pc + stage.imm;

    always_comb begin
        case (stage.op)
            op_lui:          result = stage.imm;
            op_jal, op_jalr: result = seq_pc;
            default:         result = alu_ext;
        endcase
    end

    // jalr target is rs1+imm with bit 0 cleared
    always_comb begin
        if (stage.op == op_jalr) begin
            next_pc = {alu_res[`EXU_XLEN-1:1], 1'b0};
        end else if (stage.op == op_jal || taken) begin
            next_pc = rel_pc;
        end else begin
            next_pc = seq_pc;
        end
    end

    // branches and rd 0 never write
    assign ex_fwd_valid = stage.valid && !is_branch && stage.rd != '0;
    assign ex_fwd_rd    = stage.rd;
    assign ex_fwd_data  = result;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            wb_wen    <= 1'b0;
            wb_rd     <= '0;
        end else begin
            out_valid <= stage.valid;
            wb_wen    <= ex_fwd_valid;
            // rd and data read zero on a suppressed write
            wb_rd     <= ex_fwd_valid ? stage.rd : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (stage.valid) begin
            wb_data     <= ex_fwd_valid ? result : '0;
            out_next_pc <= next_pc;
        end
    end

endmodule

// ==== logic/exu_top.sv ====
`timescale 1ns/100ps

`include "exu_params.svh"

module exu_top import exu_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       in_valid,
    input  exu_op_e                    in_op,
    input  logic                       in_use_imm,
    input  logic [`EXU_REG_ADDR_W-1:0] in_rd,
    input  logic [`EXU_REG_ADDR_W-1:0] in_rs1,
    input  logic [`EXU_REG_ADDR_W-1:0] in_rs2,
    input  logic [`EXU_XLEN-1:0]       in_imm,
    input  logic [`EXU_XLEN-1:0]       in_pc,
    output logic                       out_valid,
    output logic                       out_wen,
    output logic [`EXU_REG_ADDR_W-1:0] out_rd,
    output logic [`EXU_XLEN-1:0]       out_data,
    output logic [`EXU_XLEN-1:0]       out_next_pc
);

    logic [`EXU_REG_ADDR_W-1:0] rf_rs1_addr;
    logic [`EXU_REG_ADDR_W-1:0] rf_rs2_addr;
    logic [`EXU_XLEN-1:0]       rf_rs1_data;
    logic [`EXU_XLEN-1:0]       rf_rs2_data;
    logic                       ex_fwd_valid;
    logic [`EXU_REG_ADDR_W-1:0] ex_fwd_rd;
    logic [`EXU_XLEN-1:0]       ex_fwd_data;
    logic                       wb_wen;
    logic [`EXU_REG_ADDR_W-1:0] wb_rd;
    logic [`EXU_XLEN-1:0]       wb_data;

    // operand to execute pipeline register
    exu_stage_if stage_bus ();

    exu_operand_stage operand_stage_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_op        (in_op),
        .in_use_imm   (in_use_imm),
        .in_rd        (in_rd),
        .in_rs1       (in_rs1),
        .in_rs2       (in_rs2),
        .in_imm       (in_imm),
        .in_pc        (in_pc),
        .rf_rs1_addr  (rf_rs1_addr),
        .rf_rs2_addr  (rf_rs2_addr),
        .rf_rs1_data  (rf_rs1_data),
        .rf_rs2_data  (rf_rs2_data),
        .ex_fwd_valid (ex_fwd_valid),
        .ex_fwd_rd    (ex_fwd_rd),
        .ex_fwd_data  (ex_fwd_data),
        .wb_wen       (wb_wen),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .stage        (stage_bus.producer)
    );

    exu_execute_stage execute_stage_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .stage        (stage_bus.consumer),
        .ex_fwd_valid (ex_fwd_valid),
        .ex_fwd_rd    (ex_fwd_rd),
        .ex_fwd_data  (ex_fwd_data),
        .wb_wen       (wb_wen),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .out_valid    (out_valid),
        .out_next_pc  (out_next_pc)
    );

    // written one cycle after the result shows on the outputs
    exu_reg_file reg_file_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (rf_rs1_addr),
        .rs2_addr (rf_rs2_addr),
        .wen      (wb_wen),
        .waddr    (wb_rd),
        .wdata    (wb_data),
        .rs1_data (rf_rs1_data),
        .rs2_data (rf_rs2_data)
    );

    // writeback registers double as the result outputs
    assign out_wen  = wb_wen;
    assign out_rd   = wb_rd;
    assign out_data = wb_data;

endmodule

// ==== test/exu_clock_gen.sv ====
`timescale 1ns/100ps

module exu_clock_gen (
    output logic clk,
    output logic rst_n
);

    localparam int half_period  = 5;
    localparam int reset_cycles = 8;

    // 10 ns period, starts low
    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // released after the eighth rising edge has sampled it low
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// ==== test/exu_props.sv ====
`timescale 1ns/100ps

`include "exu_params.svh"

module exu_props (
    input logic                       clk,
    input logic                       rst_n,
    input logic                       in_valid,
    input logic                       out_valid,
    input logic                       out_wen,
    input logic [`EXU_REG_ADDR_W-1:0] out_rd
);

    // fixed two cycle latency, one result per strobe
    a_latency: assert property (
        @(posedge clk) disable iff (!rst_n) out_valid == $past(in_valid, 2)
    ) else $error("out_valid does not follow in_valid by two cycles");

    // write only with a result
    a_wen_valid: assert property (
        @(posedge clk) disable iff (!rst_n) out_wen |-> out_valid
    ) else $error("out_wen high without out_valid");

    // x0 is never written
    a_wen_rd: assert property (
        @(posedge clk) disable iff (!rst_n) out_wen |-> (out_rd != '0)
    ) else $error("out_wen high with out_rd zero");

endmodule

bind exu_top exu_props exu_props_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .out_wen   (out_wen),
    .out_rd    (out_rd)
);

// ==== test/exu_tb.sv ====
`timescale 1ns/100ps

`include "exu_params.svh"

module exu_tb import exu_pkg::*; ();

    localparam int unsigned seed  = 32'hef8f;
    localparam int num_directed   = 19;
    localparam int num_random     = 400;
    localparam int num_insns      = num_directed + num_random;
    // at most three cycles per instruction
    localparam int timeout_cycles = num_insns * 3 + 50;

    // one expected result, due is the cycle its out_valid shows
    typedef struct packed {
        logic [31:0]                due;
        logic                       wen;
        logic [`EXU_REG_ADDR_W-1:0] rd;
        logic [`EXU_XLEN-1:0]       data;
        logic [`EXU_XLEN-1:0]       next_pc;
    } exp_t;

    logic                       clk;
    logic                       rst_n;
    logic                       in_valid;
    exu_op_e                    in_op;
    logic                       in_use_imm;
    logic [`EXU_REG_ADDR_W-1:0] in_rd;
    logic [`EXU_REG_ADDR_W-1:0] in_rs1;
    logic [`EXU_REG_ADDR_W-1:0] in_rs2;
    logic [`EXU_XLEN-1:0]       in_imm;
    logic [`EXU_XLEN-1:0]       in_pc;
    logic                       out_valid;
    logic                       out_wen;
    logic [`EXU_REG_ADDR_W-1:0] out_rd;
    logic [`EXU_XLEN-1:0]       out_data;
    logic [`EXU_XLEN-1:0]       out_next_pc;

    // architectural state in issue order
    logic [`EXU_XLEN-1:0] shadow [`EXU_NUM_REGS];
    exp_t                 expect_q [$];
    int unsigned          cycle_cnt;
    logic [`EXU_REG_ADDR_W-1:0] last_rd [2];

    exu_clock_gen clock_gen_inst (
        .clk   (clk),
        .rst_n (rst_n)
    );

    exu_top exu_top_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_op       (in_op),
        .in_use_imm  (in_use_imm),
        .in_rd       (in_rd),
        .in_rs1      (in_rs1),
        .in_rs2      (in_rs2),
        .in_imm      (in_imm),
        .in_pc       (in_pc),
        .out_valid   (out_valid),
        .out_wen     (out_wen),
        .out_rd      (out_rd),
        .out_data    (out_data),
        .out_next_pc (out_next_pc)
    );

    task automatic abort_run();
        $display("Errors found");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("Fail %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    function automatic logic [`EXU_XLEN-1:0] sign_extend_word(input logic [31:0] w);
        return {{32{w[31]}}, w};
    endfunction

    // expected result straight from the instruction rules
    function automatic exp_t model(
        input exu_op_e                    op,
        input logic                       use_imm,
        input logic [`EXU_REG_ADDR_W-1:0] rd,
        input logic [`EXU_REG_ADDR_W-1:0] rs1,
        input logic [`EXU_REG_ADDR_W-1:0] rs2,
        input logic [`EXU_XLEN-1:0]       imm,
        input logic [`EXU_XLEN-1:0]       pc
    );
        exp_t                 e;
        logic [`EXU_XLEN-1:0] a;
        logic [`EXU_XLEN-1:0] s2;
        logic [`EXU_XLEN-1:0] b;
        logic [`EXU_XLEN-1:0] res;
        logic [`EXU_XLEN-1:0] step_pc;
        logic [31:0]          w;
        logic                 taken;
        logic                 writes;
        a       = shadow[rs1];
        s2      = shadow[rs2];
        b       = use_imm ? imm : s2;
        step_pc = pc + `EXU_INSN_STEP;
        res     = '0;
        taken   = 1'b0;
        case (op)
            op_add:   res = a + b;
            op_sub:   res = a - b;
            op_sll:   res = a << b[5:0];
            op_slt:   res = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            op_sltu:  res = (a < b) ? 64'd1 : 64'd0;
            op_xor:   res = a ^ b;
            op_srl:   res = a >> b[5:0];
            op_sra:   res = $signed(a) >>> b[5:0];
            op_or:    res = a | b;
            op_and:   res = a & b;
            op_addw:  res = sign_extend_word(a[31:0] + b[31:0]);
            op_subw:  res = sign_extend_word(a[31:0] - b[31:0]);
            op_sllw:  res = sign_extend_word(a[31:0] << b[4:0]);
            op_srlw:  res = sign_extend_word(a[31:0] >> b[4:0]);
            op_sraw: begin
                w   = $signed(a[31:0]) >>> b[4:0];
                res = sign_extend_word(w);
            end
            op_lui:   res = imm;
            op_auipc: res = pc + imm;
            op_jal, op_jalr: res = step_pc;
            // branches compare raw register values
            op_beq:   taken = a == s2;
            op_bne:   taken = a != s2;
            op_blt:   taken = $signed(a) < $signed(s2);
            op_bge:   taken = $signed(a) >= $signed(s2);
            op_bltu:  taken = a < s2;
            op_bgeu:  taken = a >= s2;
            default:  res = '0;
        endcase
        if (op == op_jal) begin
            e.next_pc = pc + imm;
        end else if (op == op_jalr) begin
            e.next_pc = (a + imm) & ~64'h1;
        end else begin
            e.next_pc = taken ? pc + imm : step_pc;
        end
        writes = !(op inside {op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu}) && rd != '0;
        e.due  = '0;
        e.wen  = writes;
        e.rd   = writes ? rd : '0;
        e.data = writes ? res : '0;
        return e;
    endfunction

    // drive one strobe and queue its expected result
    task automatic issue(
        input exu_op_e                    op,
        input logic                       use_imm,
        input logic [`EXU_REG_ADDR_W-1:0] rd,
        input logic [`EXU_REG_ADDR_W-1:0] rs1,
        input logic [`EXU_REG_ADDR_W-1:0] rs2,
        input logic [`EXU_XLEN-1:0]       imm,
        input logic [`EXU_XLEN-1:0]       pc
    );
        exp_t e;
        @(negedge clk);
        in_valid   = 1'b1;
        in_op      = op;
        in_use_imm = use_imm;
        in_rd      = rd;
        in_rs1     = rs1;
        in_rs2     = rs2;
        in_imm     = imm;
        in_pc      = pc;
        e          = model(op, use_imm, rd, rs1, rs2, imm, pc);
        // sampled at the next edge, result two edges later
        e.due      = cycle_cnt + 2;
        expect_q.push_back(e);
        if (e.wen) begin
            shadow[rd] = e.data;
        end
        last_rd[1] = last_rd[0];
        last_rd[0] = rd;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            in_valid = 1'b0;
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // compare on the falling edge, outputs are settled there
    always @(negedge clk) begin
        exp_t e;
        if (!rst_n) begin
            if (cycle_cnt > 0) begin
                check("out_valid", out_valid, 64'd0);
                check("out_wen", out_wen, 64'd0);
            end
        end else if (out_valid) begin
            if (expect_q.size() == 0) begin
                $display("out_valid seen with no instruction outstanding");
                abort_run();
            end else begin
                e = expect_q.pop_front();
                check("out_valid cycle", cycle_cnt, e.due);
                check("out_wen", out_wen, e.wen);
                check("out_rd", out_rd, e.rd);
                check("out_data", out_data, e.data);
                check("out_next_pc", out_next_pc, e.next_pc);
            end
        end else begin
            check("out_wen", out_wen, 64'd0);
        end
    end

    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("timeout after %0d cycles with results still missing", timeout_cycles);
        abort_run();
    end

    initial begin
        exu_op_e                    op;
        logic                       use_imm;
        logic [`EXU_REG_ADDR_W-1:0] rd;
        logic [`EXU_REG_ADDR_W-1:0] rs1;
        logic [`EXU_REG_ADDR_W-1:0] rs2;
        logic [`EXU_XLEN-1:0]       imm;
        logic [`EXU_XLEN-1:0]       pc;
        logic [31:0]                r;
        r          = $urandom(seed);
        cycle_cnt  = 0;
        in_valid   = 1'b0;
        in_op      = op_add;
        in_use_imm = 1'b0;
        in_rd      = '0;
        in_rs1     = '0;
        in_rs2     = '0;
        in_imm     = '0;
        in_pc      = '0;
        last_rd[0] = '0;
        last_rd[1] = '0;
        for (int i = 0; i < `EXU_NUM_REGS; i++) begin
            shadow[i] = '0;
        end
        @(posedge rst_n);

        // unwritten registers read zero
        issue(op_add, 1'b0, 5'd1, 5'd5, 5'd6, 64'h0, 64'h1000);
        issue(op_or, 1'b1, 5'd2, 5'd9, 5'd0, 64'h55, 64'h1004);
        // dependency at distance 1, 2 and 3
        issue(op_lui, 1'b1, 5'd10, 5'd0, 5'd0, 64'hffff_ffff_8765_4000, 64'h1008);
        issue(op_add, 1'b0, 5'd11, 5'd10, 5'd10, 64'h0, 64'h100c);
        issue(op_sub, 1'b0, 5'd12, 5'd11, 5'd10, 64'h0, 64'h1010);
        issue(op_xor, 1'b0, 5'd13, 5'd10, 5'd12, 64'h0, 64'h1014);
        issue(op_auipc, 1'b1, 5'd14, 5'd0, 5'd0, 64'h1_2000, 64'h1018);
        // both outcomes of the branches, x10 is negative
        issue(op_beq, 1'b0, 5'd0, 5'd10, 5'd10, 64'h40, 64'h101c);
        issue(op_bne, 1'b0, 5'd0, 5'd10, 5'd10, 64'h40, 64'h1020);
        issue(op_blt, 1'b0, 5'd0, 5'd10, 5'd0, -64'sd32, 64'h1024);
        issue(op_bltu, 1'b0, 5'd0, 5'd10, 5'd0, 64'h80, 64'h1028);
        issue(op_bge, 1'b0, 5'd0, 5'd0, 5'd10, 64'h100, 64'h102c);
        issue(op_bgeu, 1'b0, 5'd0, 5'd0, 5'd10, 64'h100, 64'h1030);
        // jalr target odd before bit 0 is cleared
        issue(op_jal, 1'b1, 5'd1, 5'd0, 5'd0, 64'h800, 64'h1034);
        issue(op_jalr, 1'b1, 5'd2, 5'd14, 5'd0, 64'h7, 64'h1038);
        // rd 0 writes dropped, x0 still zero right after
        issue(op_add, 1'b0, 5'd0, 5'd10, 5'd11, 64'h0, 64'h103c);
        issue(op_add, 1'b0, 5'd15, 5'd0, 5'd0, 64'h0, 64'h1040);
        issue(op_jal, 1'b1, 5'd0, 5'd0, 5'd0, 64'h20, 64'h1044);
        issue(op_or, 1'b0, 5'd17, 5'd0, 5'd10, 64'h0, 64'h1048);

        for (int i = 0; i < num_random; i++) begin
            op = exu_op_e'($urandom_range(0, 24));
            rd = 5'($urandom_range(0, 31));
            // half the sources come from the last two destinations
            rs1 = ($urandom_range(0, 1) == 1) ? last_rd[$urandom_range(0, 1)]
                                              : 5'($urandom_range(0, 31));
            rs2 = ($urandom_range(0, 1) == 1) ? last_rd[$urandom_range(0, 1)]
                                              : 5'($urandom_range(0, 31));
            if (op inside {op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu}) begin
                use_imm = 1'b0;
            end else if (op inside {op_lui, op_auipc, op_jal}) begin
                use_imm = 1'b1;
            end else begin
                use_imm = 1'($urandom_range(0, 1));
            end
            r   = $urandom;
            // short signed immediates or full width values
            imm = ($urandom_range(0, 1) == 1) ? {{52{r[11]}}, r[11:0]} : {$urandom, $urandom};
            pc  = {$urandom, $urandom} & ~64'h3;
            issue(op, use_imm, rd, rs1, rs2, imm, pc);
            if ($urandom_range(0, 2) == 0) begin
                idle($urandom_range(1, 2));
            end
        end

        idle(1);
        // last result is due two cycles after its strobe was sampled
        repeat (3) @(negedge clk);
        if (expect_q.size() != 0) begin
            $display("results still outstanding at end of run");
            abort_run();
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

// ==== vlog.f ====
+incdir+logic
logic/exu_pkg.sv
logic/exu_stage_if.sv
logic/exu_reg_file.sv
logic/exu_operand_stage.sv
logic/exu_execute_stage.sv
logic/exu_top.sv
test/exu_clock_gen.sv
test/exu_props.sv
test/exu_tb.sv
